// ==== Bender.yml ====
package:
  name: ooo_backend

sources:
  - common/ooo_pkg.sv
  - rob/reorder_buffer.sv
  - rename/map_table.sv
  - rename/free_list.sv
  - logic/arch_map.sv
  - logic/ooo_backend.sv
  - target: test
    files:
      - test/backend_asserts.sv
      - test/backend_tb.sv

// ==== build.f ====
common/ooo_pkg.sv
rob/reorder_buffer.sv
rename/map_table.sv
rename/free_list.sv
logic/arch_map.sv
logic/ooo_backend.sv
test/backend_asserts.sv
test/backend_tb.sv

// ==== common/ooo_pkg.sv ====
package ooo_pkg;

  // issue and retire width
  localparam int width = 2;

  // register file sizes
  localparam int num_arch = 32;
  localparam int num_phys = 64;

  // reorder buffer depth
  localparam int num_rob = 16;

  // physical registers beyond the identity mapping
  localparam int num_free = num_phys - num_arch;

  // architectural register, 0 means no destination
  typedef logic [$clog2(num_arch)-1:0] arch_t;

  typedef logic [$clog2(num_phys)-1:0] phys_t;

  typedef logic [$clog2(num_rob)-1:0] rob_idx_t;

  // occupancy, one bit wider so a full buffer can be counted
  typedef logic [$clog2(num_rob):0] rob_cnt_t;

  // extra msb tells full from empty
  typedef logic [$clog2(num_free):0] fl_ptr_t;

  typedef enum logic [1:0] {
    rob_run,
    rob_drain,
    rob_recover,
    rob_halted
  } rob_state_t;

endpackage

// ==== logic/arch_map.sv ====
`timescale 1ns/1ps

module arch_map
  import ooo_pkg::*;
(
  input  logic             clock,
  input  logic             reset,
  input  logic [width-1:0] retire_en,
  input  arch_t            retire_dest [width],
  input  phys_t            retire_phys [width],
  output phys_t            committed_map [num_arch]
);

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_arch; i++) begin
        committed_map[i] <= phys_t'(i);
      end
    end else begin
      // slot order, so the younger retirement wins
      for (int i = 0; i < width; i++) begin
        if (retire_en[i] && (retire_dest[i] != '0)) begin
          committed_map[retire_dest[i]] <= retire_phys[i];
        end
      end
    end
  end

endmodule

// ==== logic/ooo_backend.sv ====
`timescale 1ns/1ps

module ooo_backend
  import ooo_pkg::*;
(
  input  logic             clock,
  input  logic             reset,
  input  logic             dispatch_en,
  input  arch_t            dispatch_dest [width],
  input  logic [width-1:0] dispatch_halt,
  input  logic [width-1:0] complete_en,
  input  rob_idx_t         complete_idx [width],
  input  logic             rollback_en,
  input  rob_idx_t         rollback_idx,
  output logic             dispatch_ready,
  output rob_idx_t         dispatch_rob_idx [width],
  output phys_t            dispatch_phys [width],
  output logic [width-1:0] retire_en,
  output arch_t            retire_dest [width],
  output phys_t            retire_phys [width],
  output phys_t            retire_told [width],
  output logic             halted
);

  phys_t            dispatch_told [width];
  fl_ptr_t          free_count;
  logic             recover;
  phys_t            committed_map [num_arch];
  logic [width-1:0] commit_en;

  // only real destinations consumed a free-list entry
  always_comb begin
    for (int i = 0; i < width; i++) begin
      commit_en[i] = retire_en[i] && (retire_dest[i] != '0);
    end
  end

  reorder_buffer i_reorder_buffer (
    .clock            (clock),
    .reset            (reset),
    .dispatch_en      (dispatch_en),
    .dispatch_dest    (dispatch_dest),
    .dispatch_halt    (dispatch_halt),
    .dispatch_phys    (dispatch_phys),
    .dispatch_told    (dispatch_told),
    .free_count       (free_count),
    .complete_en      (complete_en),
    .complete_idx     (complete_idx),
    .rollback_en      (rollback_en),
    .rollback_idx     (rollback_idx),
    .dispatch_ready   (dispatch_ready),
    .dispatch_rob_idx (dispatch_rob_idx),
    .retire_en        (retire_en),
    .retire_dest      (retire_dest),
    .retire_phys      (retire_phys),
    .retire_told      (retire_told),
    .recover          (recover),
    .halted           (halted)
  );

  free_list i_free_list (
    .clock        (clock),
    .reset        (reset),
    .alloc_en     (dispatch_en),
    .alloc_dest   (dispatch_dest),
    .release_en   (retire_en),
    .release_phys (retire_told),
    .commit_en    (commit_en),
    .recover      (recover),
    .alloc_phys   (dispatch_phys),
    .free_count   (free_count)
  );

  map_table i_map_table (
    .clock         (clock),
    .reset         (reset),
    .write_en      (dispatch_en),
    .write_dest    (dispatch_dest),
    .write_phys    (dispatch_phys),
    .recover       (recover),
    .committed_map (committed_map),
    .told          (dispatch_told)
  );

  arch_map i_arch_map (
    .clock         (clock),
    .reset         (reset),
    .retire_en     (retire_en),
    .retire_dest   (retire_dest),
    .retire_phys   (retire_phys),
    .committed_map (committed_map)
  );

endmodule

// ==== rename/free_list.sv ====
`timescale 1ns/1ps

module free_list
  import ooo_pkg::*;
(
  input  logic             clock,
  input  logic             reset,
  input  logic             alloc_en,
  input  arch_t            alloc_dest [width],
  input  logic [width-1:0] release_en,
  input  phys_t            release_phys [width],
  input  logic [width-1:0] commit_en,
  input  logic             recover,
  output phys_t            alloc_phys [width],
  output fl_ptr_t          free_count
);

  phys_t            queue [num_free];

  fl_ptr_t          alloc_ptr;
  fl_ptr_t          commit_ptr;
  fl_ptr_t          release_ptr;
  fl_ptr_t          alloc_next;
  fl_ptr_t          commit_next;
  fl_ptr_t          release_next;
  fl_ptr_t          release_slot [width];
  logic [width-1:0] release_write;

  assign free_count = release_ptr - alloc_ptr;

  // next entries in order, slots without a destination take none
  always_comb begin
    alloc_next = alloc_ptr;
    for (int i = 0; i < width; i++) begin
      alloc_phys[i] = '0;
      if (alloc_dest[i] != '0) begin
        alloc_phys[i] = queue[alloc_next[$clog2(num_free)-1:0]];
        alloc_next    = alloc_next + fl_ptr_t'(1);
      end
    end
  end

  always_comb begin
    release_next = release_ptr;
    commit_next  = commit_ptr;
    for (int i = 0; i < width; i++) begin
      release_write[i] = release_en[i] && (release_phys[i] != '0);
      release_slot[i]  = release_next;
      if (release_write[i]) begin
        release_next = release_next + fl_ptr_t'(1);
      end
      if (commit_en[i]) begin
        commit_next = commit_next + fl_ptr_t'(1);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_free; i++) begin
        queue[i] <= phys_t'(num_arch + i);
      end
      alloc_ptr   <= '0;
      commit_ptr  <= '0;
      release_ptr <= fl_ptr_t'(num_free);
    end else begin
      for (int i = 0; i < width; i++) begin
        if (release_write[i]) begin
          queue[release_slot[i][$clog2(num_free)-1:0]] <= release_phys[i];
        end
      end
      release_ptr <= release_next;
      commit_ptr  <= commit_next;
      // squashed allocations go back in one step
      if (recover) begin
        alloc_ptr <= commit_ptr;
      end else if (alloc_en) begin
        alloc_ptr <= alloc_next;
      end
    end
  end

endmodule

// ==== rename/map_table.sv ====
`timescale 1ns/1ps

module map_table
  import ooo_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  logic  write_en,
  input  arch_t write_dest [width],
  input  phys_t write_phys [width],
  input  logic  recover,
  input  phys_t committed_map [num_arch],
  output phys_t told [width]
);

  phys_t map [num_arch];

  // older slots in the same pair take precedence over the stored map
  always_comb begin
    for (int i = 0; i < width; i++) begin
      told[i] = map[write_dest[i]];
      for (int j = 0; j < i; j++) begin
        if (write_dest[j] == write_dest[i]) begin
          told[i] = write_phys[j];
        end
      end
      if (write_dest[i] == '0) begin
        told[i] = '0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_arch; i++) begin
        map[i] <= phys_t'(i);
      end
    end else if (recover) begin
      map <= committed_map;
    end else if (write_en) begin
      // later slot wins on a shared destination
      for (int i = 0; i < width; i++) begin
        if (write_dest[i] != '0) begin
          map[write_dest[i]] <= write_phys[i];
        end
      end
    end
  end

endmodule

// ==== rob/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer
  import ooo_pkg::*;
(
  input  logic             clock,
  input  logic             reset,
  input  logic             dispatch_en,
  input  arch_t            dispatch_dest [width],
  input  logic [width-1:0] dispatch_halt,
  input  phys_t            dispatch_phys [width],
  input  phys_t            dispatch_told [width],
  input  fl_ptr_t          free_count,
  input  logic [width-1:0] complete_en,
  input  rob_idx_t         complete_idx [width],
  input  logic             rollback_en,
  input  rob_idx_t         rollback_idx,
  output logic             dispatch_ready,
  output rob_idx_t         dispatch_rob_idx [width],
  output logic [width-1:0] retire_en,
  output arch_t            retire_dest [width],
  output phys_t            retire_phys [width],
  output phys_t            retire_told [width],
  output logic             recover,
  output logic             halted
);

  logic [num_rob-1:0] valid;
  logic [num_rob-1:0] complete;
  logic [num_rob-1:0] halt;
  arch_t              dest [num_rob];
  phys_t              phys [num_rob];
  phys_t              told [num_rob];

  rob_idx_t           head;
  rob_idx_t           tail;
  rob_cnt_t           count;
  rob_state_t         state;
  rob_state_t         state_next;

  rob_idx_t           slot_head [width];
  rob_idx_t           roll_off;
  rob_cnt_t           retire_num;
  logic               retire_ok;
  logic               halt_retire;
  logic               rollback_ok;
  logic [num_rob-1:0] squash;

  // a full pair must fit in both the buffer and the free list
  assign dispatch_ready = (state == rob_run) && !rollback_en &&
                          (count <= rob_cnt_t'(num_rob - width)) &&
                          (free_count >= fl_ptr_t'(width));

  assign recover = (state == rob_recover);
  assign halted  = (state == rob_halted);

  // retirement holds while a rollback is presented
  assign retire_ok   = (state == rob_run || state == rob_drain) && !rollback_en;
  assign rollback_ok = rollback_en && (state == rob_run) && valid[rollback_idx];
  assign roll_off    = rollback_idx - head;

  always_comb begin
    for (int i = 0; i < width; i++) begin
      slot_head[i]        = head + rob_idx_t'(i);
      dispatch_rob_idx[i] = tail + rob_idx_t'(i);
    end
    retire_en[0] = retire_ok && valid[slot_head[0]] && complete[slot_head[0]];
    // a younger slot needs the older one retiring and not a halt
    for (int i = 1; i < width; i++) begin
      retire_en[i] = retire_en[i-1] && !halt[slot_head[i-1]] &&
                     valid[slot_head[i]] && complete[slot_head[i]];
    end
  end

  always_comb begin
    retire_num  = '0;
    halt_retire = 1'b0;
    for (int i = 0; i < width; i++) begin
      retire_dest[i] = dest[slot_head[i]];
      retire_phys[i] = phys[slot_head[i]];
      retire_told[i] = told[slot_head[i]];
      retire_num     = retire_num + rob_cnt_t'(retire_en[i]);
      halt_retire    = halt_retire || (retire_en[i] && halt[slot_head[i]]);
    end
  end

  // younger than the rollback point, measured from head
  always_comb begin
    for (int i = 0; i < num_rob; i++) begin
      squash[i] = valid[i] && (rob_idx_t'(i - head) > roll_off);
    end
  end

  always_comb begin
    state_next = state;
    unique case (state)
      rob_run: begin
        if (halt_retire) begin
          state_next = rob_halted;
        end else if (rollback_ok) begin
          state_next = rob_drain;
        end
      end
      rob_drain: begin
        if (halt_retire) begin
          state_next = rob_halted;
        end else if (count == '0) begin
          state_next = rob_recover;
        end
      end
      rob_recover: state_next = rob_run;
      rob_halted:  state_next = rob_halted;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '0;
      head  <= '0;
      tail  <= '0;
      count <= '0;
      state <= rob_run;
    end else begin
      state <= state_next;
      if (rollback_ok) begin
        valid <= valid & ~squash;
        tail  <= rollback_idx + rob_idx_t'(1);
        count <= rob_cnt_t'(roll_off) + rob_cnt_t'(1);
      end else begin
        for (int i = 0; i < width; i++) begin
          if (retire_en[i]) begin
            valid[slot_head[i]] <= 1'b0;
          end
          if (dispatch_en) begin
            valid[dispatch_rob_idx[i]] <= 1'b1;
          end
        end
        head  <= head + rob_idx_t'(retire_num);
        if (dispatch_en) begin
          tail <= tail + rob_idx_t'(width);
        end
        count <= count + (dispatch_en ? rob_cnt_t'(width) : '0) - retire_num;
      end
    end
  end

  // entry payload, only meaningful while valid
  always_ff @(posedge clock) begin
    for (int i = 0; i < width; i++) begin
      if (complete_en[i] && valid[complete_idx[i]]) begin
        complete[complete_idx[i]] <= 1'b1;
      end
    end
    if (dispatch_en) begin
      for (int i = 0; i < width; i++) begin
        // halts need no execution
        complete[dispatch_rob_idx[i]] <= dispatch_halt[i];
        halt[dispatch_rob_idx[i]]     <= dispatch_halt[i];
        dest[dispatch_rob_idx[i]]     <= dispatch_dest[i];
        phys[dispatch_rob_idx[i]]     <= dispatch_phys[i];
        told[dispatch_rob_idx[i]]     <= dispatch_told[i];
      end
    end
  end

endmodule

// ==== test/backend_asserts.sv ====
`timescale 1ns/1ps

module backend_asserts
  import ooo_pkg::*;
(
  input logic             clock,
  input logic             reset,
  input logic             dispatch_en,
  input logic             dispatch_ready,
  input phys_t            dispatch_phys [width],
  input logic [width-1:0] retire_en,
  input logic             rollback_en,
  input logic             halted
);

  int fails = 0;

  retire_in_order: assert property (@(posedge clock) disable iff (reset)
    retire_en[1] |-> retire_en[0])
    else begin
      fails++;
      $error("slot 1 retired without slot 0");
    end

  // halted freezes the whole back end
  halt_freezes: assert property (@(posedge clock) disable iff (reset)
    halted |-> (retire_en == '0) && !dispatch_ready)
    else begin
      fails++;
      $error("retire or dispatch active while halted");
    end

  rollback_blocks_dispatch: assert property (@(posedge clock) disable iff (reset)
    rollback_en |-> !dispatch_ready)
    else begin
      fails++;
      $error("dispatch_ready high during rollback");
    end

  distinct_phys: assert property (@(posedge clock) disable iff (reset)
    (dispatch_en && dispatch_ready) |->
      (dispatch_phys[0] != dispatch_phys[1]) || (dispatch_phys[0] == '0))
    else begin
      fails++;
      $error("same physical register handed to both slots");
    end

endmodule

bind ooo_backend backend_asserts i_backend_asserts (.*);

// ==== test/backend_tb.sv ====
`timescale 1ns/1ps

module backend_tb;
  import ooo_pkg::*;

  localparam int period      = 100;
  localparam int num_tests   = 6;
  localparam int test_cycles = 2000;

  typedef struct {
    arch_t    dest;
    phys_t    phys;
    phys_t    told;
    rob_idx_t idx;
    logic     halt;
    logic     done;
  } entry_t;

  logic             clock;
  logic             reset;
  logic             dispatch_en;
  arch_t            dispatch_dest [width];
  logic [width-1:0] dispatch_halt;
  logic [width-1:0] complete_en;
  rob_idx_t         complete_idx [width];
  logic             rollback_en;
  rob_idx_t         rollback_idx;
  logic             dispatch_ready;
  rob_idx_t         dispatch_rob_idx [width];
  phys_t            dispatch_phys [width];
  logic [width-1:0] retire_en;
  arch_t            retire_dest [width];
  phys_t            retire_phys [width];
  phys_t            retire_told [width];
  logic             halted;

  // model state, in-flight entries oldest first
  phys_t       fl_q [$];
  phys_t       reclaim_q [$];
  phys_t       spec_map [num_arch];
  phys_t       arch_map_m [num_arch];
  entry_t      rob_q [$];
  rob_idx_t    m_tail;
  rob_state_t  m_state;
  logic [31:0] rng;
  int          errors;
  int          checks;
  int          tests;

  ooo_backend i_ooo_backend (.*);

  initial clock = 1'b0;
  always #(period / 2) clock = ~clock;

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // small range so pairs repeat destinations and hit register 0
  function automatic arch_t random_dest();
    return arch_t'(next_rand() % 8);
  endfunction

  function automatic phys_t expected_told(arch_t dest);
    return (dest == '0) ? phys_t'(0) : spec_map[dest];
  endfunction

  function automatic logic expected_ready();
    return (m_state == rob_run) && !rollback_en && (rob_q.size() <= num_rob - width) &&
           (fl_q.size() >= width);
  endfunction

  task automatic record_check(input string what, input logic ok, input int got, input int exp);
    checks++;
    if (!ok) begin
      errors++;
      $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_phys(input string what, input phys_t got, input phys_t exp);
    record_check(what, got === exp, got, exp);
  endtask

  task automatic check_arch(input string what, input arch_t got, input arch_t exp);
    record_check(what, got === exp, got, exp);
  endtask

  task automatic check_idx(input string what, input rob_idx_t got, input rob_idx_t exp);
    record_check(what, got === exp, got, exp);
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    record_check(what, got === exp, got, exp);
  endtask

  task automatic report_test(input string name);
    tests++;
    $display("test %0d %s finished, %0d errors so far", tests, name, errors);
  endtask

  task automatic cycle();
    @(posedge clock);
    #10;
    dispatch_en = 1'b0;
    complete_en = '0;
    rollback_en = 1'b0;
  endtask

  task automatic drive_pair(input arch_t d0, input arch_t d1, input logic [width-1:0] h);
    dispatch_en      = 1'b1;
    dispatch_dest[0] = d0;
    dispatch_dest[1] = d1;
    dispatch_halt    = h;
  endtask

  task automatic dispatch(input arch_t d0, input arch_t d1, input logic [width-1:0] h);
    cycle();
    while (!dispatch_ready) begin
      cycle();
    end
    drive_pair(d0, d1, h);
  endtask

  // pulse every pending entry, up to two per cycle, in random order
  task automatic complete_all();
    rob_idx_t pend [$];
    int       k;
    cycle();
    foreach (rob_q[i]) begin
      if (!rob_q[i].done) begin
        pend.push_back(rob_q[i].idx);
      end
    end
    while (pend.size() > 0) begin
      for (int i = 0; i < width; i++) begin
        if (pend.size() > 0) begin
          k = int'(next_rand() % pend.size());
          complete_en[i]  = 1'b1;
          complete_idx[i] = pend[k];
          pend.delete(k);
        end
      end
      cycle();
    end
  endtask

  task automatic wait_empty();
    while (rob_q.size() > 0) begin
      cycle();
    end
  endtask

  // compare process, samples mid-cycle and then advances the model
  always @(negedge clock) begin
    rob_state_t next_state;
    entry_t     e;
    int         keep;
    if (!reset) begin
      next_state = m_state;
      check_flag("dispatch_ready", dispatch_ready, expected_ready());
      check_flag("halted", halted, m_state == rob_halted);
      if (m_state == rob_drain && rob_q.size() == 0) begin
        next_state = rob_recover;
      end
      if (m_state == rob_recover) begin
        spec_map   = arch_map_m;
        fl_q       = {reclaim_q, fl_q};
        reclaim_q  = {};
        next_state = rob_run;
      end
      for (int i = 0; i < width; i++) begin
        if (retire_en[i] &&
            (next_state == rob_halted || rob_q.size() == 0 || !rob_q[0].done)) begin
          errors++;
          $display("Fail at %0t ns: an entry retired that was not complete at the head",
                   $time);
        end else if (retire_en[i]) begin
          e = rob_q.pop_front();
          check_arch("retire_dest", retire_dest[i], e.dest);
          check_phys("retire_phys", retire_phys[i], e.phys);
          check_phys("retire_told", retire_told[i], e.told);
          if (e.dest != '0) begin
            arch_map_m[e.dest] = e.phys;
          end
          if (e.told != '0) begin
            fl_q.push_back(e.told);
          end
          if (e.halt) begin
            next_state = rob_halted;
          end
        end
      end
      for (int i = 0; i < width; i++) begin
        foreach (rob_q[k]) begin
          if (complete_en[i] && rob_q[k].idx == complete_idx[i]) begin
            rob_q[k].done = 1'b1;
          end
        end
      end
      if (rollback_en && m_state == rob_run) begin
        keep = 0;
        foreach (rob_q[k]) begin
          if (rob_q[k].idx == rollback_idx) begin
            keep = k + 1;
          end
        end
        // squashed allocations go back to the front in their old order
        while (rob_q.size() > keep) begin
          e = rob_q.pop_back();
          if (e.dest != '0) begin
            reclaim_q.push_front(e.phys);
          end
        end
        m_tail     = rollback_idx + rob_idx_t'(1);
        next_state = rob_drain;
      end
      if (dispatch_en && dispatch_ready) begin
        for (int i = 0; i < width; i++) begin
          e.dest = dispatch_dest[i];
          e.phys = (e.dest == '0) ? phys_t'(0) : fl_q.pop_front();
          e.told = expected_told(e.dest);
          e.idx  = m_tail + rob_idx_t'(i);
          e.halt = dispatch_halt[i];
          e.done = dispatch_halt[i];
          check_idx("dispatch_rob_idx", dispatch_rob_idx[i], e.idx);
          check_phys("dispatch_phys", dispatch_phys[i], e.phys);
          if (e.dest != '0) begin
            spec_map[e.dest] = e.phys;
          end
          rob_q.push_back(e);
        end
        m_tail = m_tail + rob_idx_t'(width);
      end
      m_state = next_state;
    end
  end

  initial begin
    rob_idx_t squashed [$];
    rng           = 32'd53876;
    errors        = 0;
    checks        = 0;
    tests         = 0;
    reset         = 1'b1;
    dispatch_en   = 1'b0;
    dispatch_dest = '{default: '0};
    dispatch_halt = '0;
    complete_en   = '0;
    complete_idx  = '{default: '0};
    rollback_en   = 1'b0;
    rollback_idx  = '0;
    for (int i = 0; i < num_arch; i++) begin
      spec_map[i]   = phys_t'(i);
      arch_map_m[i] = phys_t'(i);
    end
    for (int i = 0; i < num_free; i++) begin
      fl_q.push_back(phys_t'(num_arch + i));
    end
    m_tail  = '0;
    m_state = rob_run;
    repeat (3) @(posedge clock);
    #10;
    reset = 1'b0;

    repeat (5) dispatch(random_dest(), random_dest(), '0);
    report_test("renaming");

    complete_all();
    wait_empty();
    report_test("in-order retirement");

    dispatch(random_dest(), random_dest(), '0);
    cycle();
    complete_en     = '1;
    complete_idx[0] = rob_q[0].idx;
    complete_idx[1] = rob_q[1].idx;
    cycle();
    check_flag("both head entries retiring", retire_en == '1, 1'b1);
    // younger slot done first must wait for the head
    dispatch(random_dest(), random_dest(), '0);
    cycle();
    complete_en[1]  = 1'b1;
    complete_idx[1] = rob_q[rob_q.size() - 1].idx;
    repeat (3) cycle();
    complete_all();
    wait_empty();
    report_test("retire width and gating");

    cycle();
    while (dispatch_ready) begin
      drive_pair(random_dest(), random_dest(), '0);
      cycle();
    end
    check_flag("dispatch blocked only when buffer full", rob_q.size() == num_rob, 1'b1);
    repeat (2) cycle();
    complete_all();
    wait_empty();
    report_test("back-pressure");

    repeat (4) dispatch(random_dest(), random_dest(), '0);
    cycle();
    for (int i = 3; i < rob_q.size(); i++) begin
      squashed.push_back(rob_q[i].idx);
    end
    rollback_en  = 1'b1;
    rollback_idx = rob_q[2].idx;
    while (squashed.size() > 0) begin
      cycle();
      complete_en[0]  = 1'b1;
      complete_idx[0] = squashed.pop_front();
    end
    complete_all();
    wait_empty();
    repeat (3) dispatch(random_dest(), random_dest(), '0);
    complete_all();
    wait_empty();
    report_test("rollback");

    dispatch(random_dest(), '0, 2'b10);
    dispatch(random_dest(), random_dest(), '0);
    complete_all();
    while (!halted) begin
      cycle();
    end
    repeat (4) cycle();
    check_flag("retire_en while younger entries wait after halt", retire_en == '0, 1'b1);
    report_test("halt");

    errors = errors + i_ooo_backend.i_backend_asserts.fails;
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #(num_tests * test_cycles * period);
    $display("timeout after %0d cycles, the tests stopped making progress",
             num_tests * test_cycles);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule
